// File: src/RenameTypes.sv
/*
 * Shared definitions for the rename unit
 * Micro-op word layout, logical register widths,
 * op class encoding and serializer phases
 */
`default_nettype none

package RenameTypes;

    localparam int OpWordWidth  = 12;
    localparam int OpClassWidth = 3;
    localparam int LogRegWidth  = 3;
    localparam int LogRegs      = 2 ** LogRegWidth;

    // Field positions, class in the top bits
    localparam int ClassLsb = OpWordWidth - OpClassWidth;
    localparam int DstLsb   = ClassLsb - LogRegWidth;
    localparam int SrcALsb  = DstLsb - LogRegWidth;
    localparam int SrcBLsb  = SrcALsb - LogRegWidth;

    // Codes 6 and 7 are illegal and rename as OP_ALU
    typedef enum logic [OpClassWidth-1:0] {
        OP_ALU    = 3'd0,
        OP_LOAD   = 3'd1,
        OP_STORE  = 3'd2,
        OP_BRANCH = 3'd3,
        OP_SYSTEM = 3'd4,
        OP_FENCE  = 3'd5
    } OpClass;

    typedef enum logic {
        PHASE_NORMAL   = 1'b0,
        PHASE_WAIT_OWN = 1'b1
    } SerialPhase;

endpackage

`default_nettype wire

// File: src/RenameOpDecoder.sv
/*
 * Micro-op decoder
 * Slices class and register fields, derives read/write and class flags
 */
`timescale 1ns/1ps
`default_nettype none

module RenameOpDecoder (
    input  logic [RenameTypes::OpWordWidth-1:0] opWord,
    output RenameTypes::OpClass                 opClass,
    output logic [RenameTypes::LogRegWidth-1:0] logDst,
    output logic [RenameTypes::LogRegWidth-1:0] logSrcA,
    output logic [RenameTypes::LogRegWidth-1:0] logSrcB,
    output logic writeReg,
    output logic readA,
    output logic readB,
    output logic isLoad,
    output logic isStore,
    output logic isBranch,
    output logic serialized,
    output logic isFence,
    output logic undefined
);
    logic [RenameTypes::OpClassWidth-1:0] rawClass;

    assign rawClass  = opWord[RenameTypes::ClassLsb +: RenameTypes::OpClassWidth];
    assign undefined = rawClass > RenameTypes::OpClassWidth'(RenameTypes::OP_FENCE);
    assign opClass   = undefined ? RenameTypes::OP_ALU : RenameTypes::OpClass'(rawClass);

    always_comb begin
        writeReg = 1'b0;
        readA    = 1'b0;
        readB    = 1'b0;
        case (opClass)
            RenameTypes::OP_ALU: begin
                writeReg = 1'b1;
                readA    = 1'b1;
                readB    = 1'b1;
            end
            RenameTypes::OP_LOAD: begin
                writeReg = 1'b1;
                readA    = 1'b1;
            end
            RenameTypes::OP_STORE, RenameTypes::OP_BRANCH: begin
                readA = 1'b1;
                readB = 1'b1;
            end
            RenameTypes::OP_SYSTEM: writeReg = 1'b1;
            default: ;
        endcase
    end

    assign isLoad     = opClass == RenameTypes::OP_LOAD;
    assign isStore    = opClass == RenameTypes::OP_STORE;
    assign isBranch   = opClass == RenameTypes::OP_BRANCH;
    assign isFence    = opClass == RenameTypes::OP_FENCE;
    assign serialized = isFence || opClass == RenameTypes::OP_SYSTEM;

    // Unused fields read as register 0
    assign logDst  = writeReg ? opWord[RenameTypes::DstLsb +: RenameTypes::LogRegWidth] : '0;
    assign logSrcA = readA ? opWord[RenameTypes::SrcALsb +: RenameTypes::LogRegWidth] : '0;
    assign logSrcB = readB ? opWord[RenameTypes::SrcBLsb +: RenameTypes::LogRegWidth] : '0;

endmodule

`default_nettype wire

// File: src/RenameSerializer.sv
/*
 * Serialization FSM for system and fence ops
 * Holds the op until older ops drain, then holds younger ops
 * until the serialized op itself has committed
 */
`timescale 1ns/1ps
`default_nettype none

module RenameSerializer (
    input  logic clk,
    input  logic rst,
    input  logic stall,
    input  logic clear,
    input  logic opValid,
    input  logic serialized,
    input  logic isFence,
    input  logic activeListEmpty,
    input  logic storeQueueEmpty,
    output logic serialize
);
    RenameTypes::SerialPhase phase;
    RenameTypes::SerialPhase nextPhase;
    logic olderPending;

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            phase <= RenameTypes::PHASE_NORMAL;
        end else if (!stall) begin
            phase <= nextPhase;
        end
    end

    // A fence also waits for committed stores to drain
    assign olderPending = !activeListEmpty || (isFence && !storeQueueEmpty);

    always_comb begin
        serialize = 1'b0;
        nextPhase = phase;
        case (phase)
            RenameTypes::PHASE_NORMAL: begin
                if (opValid && serialized) begin
                    if (olderPending) begin
                        serialize = 1'b1;
                    end else begin
                        // Let the op itself through
                        nextPhase = RenameTypes::PHASE_WAIT_OWN;
                    end
                end
            end
            default: begin
                // Waiting on the serialized op's own commit
                if (!activeListEmpty || !storeQueueEmpty) begin
                    serialize = 1'b1;
                end else if (opValid && serialized) begin
                    // Next serialized op goes through and is waited on in turn
                    nextPhase = RenameTypes::PHASE_WAIT_OWN;
                end else begin
                    nextPhase = RenameTypes::PHASE_NORMAL;
                end
            end
        endcase
    end

endmodule

`default_nettype wire

// File: src/RenameMapTable.sv
/*
 * Register map table and free list
 * Logical-to-physical map with combinational lookup,
 * circular free list popped at rename and pushed at commit
 */
`timescale 1ns/1ps
`default_nettype none

module RenameMapTable #(
    parameter int PhysRegs = 16,
    localparam int PhysWidth = $clog2(PhysRegs)
) (
    input  logic clk,
    input  logic rst,
    input  logic update,
    input  logic writeReg,
    input  logic [RenameTypes::LogRegWidth-1:0] logSrcA,
    input  logic [RenameTypes::LogRegWidth-1:0] logSrcB,
    input  logic [RenameTypes::LogRegWidth-1:0] logDst,
    input  logic readA,
    input  logic readB,
    input  logic freeValid,
    input  logic [PhysWidth-1:0] freeReg,
    output logic [PhysWidth-1:0] phySrcA,
    output logic [PhysWidth-1:0] phySrcB,
    output logic [PhysWidth-1:0] phyDst,
    output logic [PhysWidth-1:0] phyPrevDst,
    output logic freeListEmpty
);
    localparam int FreeSlots    = PhysRegs - RenameTypes::LogRegs;
    localparam int FreePtrWidth = (FreeSlots > 1) ? $clog2(FreeSlots) : 1;
    localparam int CountWidth   = $clog2(FreeSlots + 1);

    logic [PhysWidth-1:0]    mapTable [RenameTypes::LogRegs];
    logic [PhysWidth-1:0]    freeList [FreeSlots];
    logic [FreePtrWidth-1:0] head;
    logic [FreePtrWidth-1:0] tail;
    logic [CountWidth-1:0]   count;
    logic pop;

    // Slot count need not be a power of two
    function automatic logic [FreePtrWidth-1:0] advance(input logic [FreePtrWidth-1:0] ptr);
        return (ptr == FreePtrWidth'(FreeSlots - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign pop           = update && writeReg;
    assign freeListEmpty = count == '0;

    // Unread sources and non-writing ops report register 0
    assign phySrcA    = readA ? mapTable[logSrcA] : '0;
    assign phySrcB    = readB ? mapTable[logSrcB] : '0;
    assign phyDst     = writeReg ? freeList[head] : '0;
    assign phyPrevDst = writeReg ? mapTable[logDst] : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            // Identity map, registers above the logical ones are free
            for (int i = 0; i < RenameTypes::LogRegs; i++) begin
                mapTable[i] <= PhysWidth'(i);
            end
            for (int i = 0; i < FreeSlots; i++) begin
                freeList[i] <= PhysWidth'(RenameTypes::LogRegs + i);
            end
            head  <= '0;
            tail  <= '0;
            count <= CountWidth'(FreeSlots);
        end else begin
            if (pop) begin
                mapTable[logDst] <= freeList[head];
                head             <= advance(head);
            end
            if (freeValid) begin
                freeList[tail] <= freeReg;
                tail           <= advance(tail);
            end
            if (freeValid && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !freeValid) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/RenameActiveList.sv
/*
 * In-order active list
 * Allocation at the tail on rename, retirement at the head on commit,
 * registered commit results and same-cycle register release
 */
`timescale 1ns/1ps
`default_nettype none

module RenameActiveList #(
    parameter int ActiveListDepth = 8,
    parameter int PhysRegs = 16,
    localparam int PtrWidth = $clog2(ActiveListDepth),
    localparam int PhysWidth = $clog2(PhysRegs)
) (
    input  logic clk,
    input  logic rst,
    input  logic update,
    input  logic writeReg,
    input  logic undefined,
    input  logic [RenameTypes::LogRegWidth-1:0] logDst,
    input  logic [PhysWidth-1:0] phyDst,
    input  logic [PhysWidth-1:0] phyPrevDst,
    input  logic commit,
    output logic [PtrWidth-1:0] tailPtr,
    output logic empty,
    output logic full,
    output logic freeValid,
    output logic [PhysWidth-1:0] freeReg,
    output logic commitValid,
    output logic [RenameTypes::LogRegWidth-1:0] commitLogDst,
    output logic [PhysWidth-1:0] commitPhyDst,
    output logic commitUndefined
);
    logic [RenameTypes::LogRegWidth-1:0] entryLogDst     [ActiveListDepth];
    logic [PhysWidth-1:0]                entryPhyDst     [ActiveListDepth];
    logic [PhysWidth-1:0]                entryPhyPrevDst [ActiveListDepth];
    logic                                entryWriteReg   [ActiveListDepth];
    logic                                entryUndefined  [ActiveListDepth];

    logic [PtrWidth-1:0] head;
    logic [PtrWidth:0]   count;
    logic pop;

    assign empty   = count == '0;
    assign full    = count == (PtrWidth + 1)'(ActiveListDepth);
    assign tailPtr = head + count[PtrWidth-1:0];

    // A commit on an empty list is dropped
    assign pop = commit && !empty;

    // The old mapping of a retired writer goes back to the free list
    assign freeValid = pop && entryWriteReg[head];
    assign freeReg   = entryPhyPrevDst[head];

    always_ff @(posedge clk) begin
        if (update) begin
            entryLogDst[tailPtr]     <= logDst;
            entryPhyDst[tailPtr]     <= phyDst;
            entryPhyPrevDst[tailPtr] <= phyPrevDst;
            entryWriteReg[tailPtr]   <= writeReg;
            entryUndefined[tailPtr]  <= undefined;
        end
        commitLogDst    <= entryLogDst[head];
        commitPhyDst    <= entryPhyDst[head];
        commitUndefined <= entryUndefined[head];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head        <= '0;
            count       <= '0;
            commitValid <= 1'b0;
        end else begin
            commitValid <= pop;
            if (pop) begin
                head <= head + 1'b1;
            end
            if (update && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !update) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/RenameStage.sv
/*
 * Rename stage
 * Stage register, stall and allocation strobe, renamed result output
 */
`timescale 1ns/1ps
`default_nettype none

module RenameStage #(
    parameter int PhysRegs = 16,
    parameter int ActiveListDepth = 8,
    localparam int PhysWidth = $clog2(PhysRegs),
    localparam int PtrWidth = $clog2(ActiveListDepth)
) (
    input  logic clk,
    input  logic rst,
    input  logic flush,
    input  logic opValid,
    input  logic [RenameTypes::OpWordWidth-1:0] opWord,
    input  logic writeReg,
    input  logic isLoad,
    input  logic isStore,
    input  logic isBranch,
    input  logic serialized,
    input  logic isFence,
    input  logic freeListEmpty,
    input  logic activeListFull,
    input  logic activeListEmpty,
    input  logic storeQueueEmpty,
    input  logic [PhysWidth-1:0] phySrcA,
    input  logic [PhysWidth-1:0] phySrcB,
    input  logic [PhysWidth-1:0] phyDst,
    input  logic [PhysWidth-1:0] phyPrevDst,
    input  logic [PtrWidth-1:0] activeListPtr,
    output logic inReady,
    output logic [RenameTypes::OpWordWidth-1:0] heldWord,
    output logic update,
    output logic outValid,
    output logic [PhysWidth-1:0] outPhySrcA,
    output logic [PhysWidth-1:0] outPhySrcB,
    output logic [PhysWidth-1:0] outPhyDst,
    output logic [PhysWidth-1:0] outPhyPrevDst,
    output logic [PtrWidth-1:0] outActiveListPtr,
    output logic outIsLoad,
    output logic outIsStore,
    output logic outIsBranch
);
    logic heldValid;
    logic resourceStall;
    logic serialize;
    logic stall;

    // Resource stall only, serialize depends on the phase register
    assign resourceStall = heldValid && ((writeReg && freeListEmpty) || activeListFull);
    assign stall         = resourceStall || serialize;
    assign update        = heldValid && !flush && !stall;
    assign inReady       = !heldValid || update;

    RenameSerializer serializer (
        .clk            (clk),
        .rst            (rst),
        .stall          (resourceStall),
        .clear          (flush),
        .opValid        (heldValid),
        .serialized     (serialized),
        .isFence        (isFence),
        .activeListEmpty(activeListEmpty),
        .storeQueueEmpty(storeQueueEmpty),
        .serialize      (serialize)
    );

    // A flushed op is dropped, a new op may still enter at that edge
    always_ff @(posedge clk) begin
        if (rst) begin
            heldValid <= 1'b0;
        end else if (opValid && inReady) begin
            heldValid <= 1'b1;
        end else if (update || flush) begin
            heldValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (opValid && inReady) begin
            heldWord <= opWord;
        end
    end

    // Renamed result is valid in the allocation cycle
    assign outValid         = update;
    assign outPhySrcA       = phySrcA;
    assign outPhySrcB       = phySrcB;
    assign outPhyDst        = phyDst;
    assign outPhyPrevDst    = phyPrevDst;
    assign outActiveListPtr = activeListPtr;
    assign outIsLoad        = isLoad;
    assign outIsStore       = isStore;
    assign outIsBranch      = isBranch;

endmodule

`default_nettype wire

// File: src/RenameUnit.sv
/*
 * Rename unit top level
 * Decoder, rename stage, map table and active list
 */
`timescale 1ns/1ps
`default_nettype none

module RenameUnit #(
    parameter int PhysRegs = 16,
    parameter int ActiveListDepth = 8,
    localparam int PhysWidth = $clog2(PhysRegs),
    localparam int PtrWidth = $clog2(ActiveListDepth)
) (
    input  logic clk,
    input  logic rst,
    input  logic opValid,
    input  logic [RenameTypes::OpWordWidth-1:0] opWord,
    input  logic commit,
    input  logic storeQueueEmpty,
    input  logic flush,
    output logic inReady,
    output logic outValid,
    output logic [PhysWidth-1:0] outPhySrcA,
    output logic [PhysWidth-1:0] outPhySrcB,
    output logic [PhysWidth-1:0] outPhyDst,
    output logic [PhysWidth-1:0] outPhyPrevDst,
    output logic [PtrWidth-1:0] outActiveListPtr,
    output logic outIsLoad,
    output logic outIsStore,
    output logic outIsBranch,
    output logic commitValid,
    output logic [RenameTypes::LogRegWidth-1:0] commitLogDst,
    output logic [PhysWidth-1:0] commitPhyDst,
    output logic commitUndefined
);
    logic [RenameTypes::OpWordWidth-1:0] heldWord;
    logic [RenameTypes::LogRegWidth-1:0] logDst;
    logic [RenameTypes::LogRegWidth-1:0] logSrcA;
    logic [RenameTypes::LogRegWidth-1:0] logSrcB;
    logic writeReg, readA, readB, isLoad, isStore, isBranch;
    logic serialized, isFence, undefined;
    logic update;
    logic [PhysWidth-1:0] phySrcA, phySrcB, phyDst, phyPrevDst;
    logic freeListEmpty;
    logic [PtrWidth-1:0] alTailPtr;
    logic alEmpty, alFull;
    logic freeValid;
    logic [PhysWidth-1:0] freeReg;

    // Class is consumed inside the decoder only
    RenameOpDecoder decoder (
        .opWord    (heldWord),
        .opClass   (),
        .logDst    (logDst),
        .logSrcA   (logSrcA),
        .logSrcB   (logSrcB),
        .writeReg  (writeReg),
        .readA     (readA),
        .readB     (readB),
        .isLoad    (isLoad),
        .isStore   (isStore),
        .isBranch  (isBranch),
        .serialized(serialized),
        .isFence   (isFence),
        .undefined (undefined)
    );

    RenameStage #(
        .PhysRegs       (PhysRegs),
        .ActiveListDepth(ActiveListDepth)
    ) stage (
        .clk             (clk),
        .rst             (rst),
        .flush           (flush),
        .opValid         (opValid),
        .opWord          (opWord),
        .writeReg        (writeReg),
        .isLoad          (isLoad),
        .isStore         (isStore),
        .isBranch        (isBranch),
        .serialized      (serialized),
        .isFence         (isFence),
        .freeListEmpty   (freeListEmpty),
        .activeListFull  (alFull),
        .activeListEmpty (alEmpty),
        .storeQueueEmpty (storeQueueEmpty),
        .phySrcA         (phySrcA),
        .phySrcB         (phySrcB),
        .phyDst          (phyDst),
        .phyPrevDst      (phyPrevDst),
        .activeListPtr   (alTailPtr),
        .inReady         (inReady),
        .heldWord        (heldWord),
        .update          (update),
        .outValid        (outValid),
        .outPhySrcA      (outPhySrcA),
        .outPhySrcB      (outPhySrcB),
        .outPhyDst       (outPhyDst),
        .outPhyPrevDst   (outPhyPrevDst),
        .outActiveListPtr(outActiveListPtr),
        .outIsLoad       (outIsLoad),
        .outIsStore      (outIsStore),
        .outIsBranch     (outIsBranch)
    );

    RenameMapTable #(
        .PhysRegs(PhysRegs)
    ) mapTable (
        .clk          (clk),
        .rst          (rst),
        .update       (update),
        .writeReg     (writeReg),
        .logSrcA      (logSrcA),
        .logSrcB      (logSrcB),
        .logDst       (logDst),
        .readA        (readA),
        .readB        (readB),
        .freeValid    (freeValid),
        .freeReg      (freeReg),
        .phySrcA      (phySrcA),
        .phySrcB      (phySrcB),
        .phyDst       (phyDst),
        .phyPrevDst   (phyPrevDst),
        .freeListEmpty(freeListEmpty)
    );

    RenameActiveList #(
        .ActiveListDepth(ActiveListDepth),
        .PhysRegs       (PhysRegs)
    ) activeList (
        .clk            (clk),
        .rst            (rst),
        .update         (update),
        .writeReg       (writeReg),
        .undefined      (undefined),
        .logDst         (logDst),
        .phyDst         (phyDst),
        .phyPrevDst     (phyPrevDst),
        .commit         (commit),
        .tailPtr        (alTailPtr),
        .empty          (alEmpty),
        .full           (alFull),
        .freeValid      (freeValid),
        .freeReg        (freeReg),
        .commitValid    (commitValid),
        .commitLogDst   (commitLogDst),
        .commitPhyDst   (commitPhyDst),
        .commitUndefined(commitUndefined)
    );

endmodule

`default_nettype wire

// File: tests/RenameUnitChecks.svh
/*
 * Compare tasks for the rename unit testbench
 * Rename result fields and registered commit results
 */

task automatic checkRename(
    input logic [PhysWidth-1:0] gotSrcA,
    input logic [PhysWidth-1:0] gotSrcB,
    input logic [PhysWidth-1:0] gotDst,
    input logic [PhysWidth-1:0] gotPrev,
    input logic [PtrWidth-1:0]  gotPtr,
    input logic [2:0]           gotFlags,
    input logic [RenameWidth-1:0] exp
);
    logic [RenameWidth-1:0] got;
    got = {gotSrcA, gotSrcB, gotDst, gotPrev, gotPtr, gotFlags};
    if (got !== exp) begin
        reportMismatch($sformatf(
            "rename src %0d/%0d dst %0d prev %0d ptr %0d flags %b, expected %0d/%0d %0d %0d %0d %b",
            gotSrcA, gotSrcB, gotDst, gotPrev, gotPtr, gotFlags,
            exp[21:18], exp[17:14], exp[13:10], exp[9:6], exp[5:3], exp[2:0]));
    end
endtask

task automatic checkCommit(
    input logic [RenameTypes::LogRegWidth-1:0] gotLog,
    input logic [PhysWidth-1:0]                gotPhy,
    input logic                                gotUndef,
    input logic [CommitWidth-1:0]              exp
);
    if ({gotLog, gotPhy, gotUndef} !== exp) begin
        reportMismatch($sformatf("commit log %0d phy %0d undef %b, expected %0d %0d %b",
            gotLog, gotPhy, gotUndef, exp[7:5], exp[4:1], exp[0]));
    end
endtask

// File: tests/RenameUnitTb.sv
/*
 * Testbench for the rename unit
 * Clock, reset, directed and LFSR stimulus, reference model,
 * result monitor, watchdog and summary
 */
`timescale 1ns/1ps
`default_nettype none

module RenameUnitTb;
    localparam int PhysRegs    = 16;
    localparam int Depth       = 8;
    localparam int PhysWidth   = $clog2(PhysRegs);
    localparam int PtrWidth    = $clog2(Depth);
    localparam int RenameWidth = 4 * PhysWidth + PtrWidth + 3;
    localparam int CommitWidth = RenameTypes::LogRegWidth + PhysWidth + 1;
    localparam int Period      = 20;
    localparam int TotalOps    = 460;

    logic clk = 1'b0;
    logic rst;
    logic opValid, commit, storeQueueEmpty, flush;
    logic [RenameTypes::OpWordWidth-1:0] opWord;
    logic inReady, outValid, outIsLoad, outIsStore, outIsBranch;
    logic [PhysWidth-1:0] outPhySrcA, outPhySrcB, outPhyDst, outPhyPrevDst;
    logic [PtrWidth-1:0] outActiveListPtr;
    logic commitValid, commitUndefined;
    logic [RenameTypes::LogRegWidth-1:0] commitLogDst;
    logic [PhysWidth-1:0] commitPhyDst;

    // Reference model state
    logic [PhysWidth-1:0] modelMap [8];
    logic [PhysWidth-1:0] freeQ [$];
    logic [CommitWidth-1:0] alEntry [$];
    logic [PhysWidth-1:0] alPrev [$];
    bit alWr [$];
    logic [CommitWidth-1:0] expCommit [$];
    int alHead;
    bit modelHeldValid, waitOwn;
    logic [RenameTypes::OpWordWidth-1:0] modelHeldWord;
    int renamedCount, errors, passCount, failCount;
    logic [15:0] lfsr = 16'd70;

    RenameUnit #(.PhysRegs(PhysRegs), .ActiveListDepth(Depth)) uut (.*);

    always #(Period / 2) clk = ~clk;

    task automatic reportMismatch(input string msg);
        $display("MISMATCH at %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic reportFailure(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        errors++;
    endtask

    `include "RenameUnitChecks.svh"

    // Taps 16, 14, 13, 11
    function automatic int randomBits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v = (v << 1) | lfsr[0];
        end
        return v;
    endfunction

    function automatic int refClass(input logic [11:0] w);
        return (w[11:9] > 3'd5) ? 0 : int'(w[11:9]);
    endfunction

    function automatic bit refWrites(input int c);
        return c == 0 || c == 1 || c == 4;
    endfunction

    function automatic logic [11:0] makeWord(input int c, input int d, input int a, input int b);
        return {3'(c), 3'(d), 3'(a), 3'(b)};
    endfunction

    // Expected rename result from the model state
    function automatic logic [RenameWidth-1:0] expectRename(input logic [11:0] w);
        int c;
        logic [PhysWidth-1:0] a, b, d, p;
        logic [PtrWidth-1:0] ptr;
        c   = refClass(w);
        a   = (c <= 3) ? modelMap[w[5:3]] : '0;
        b   = (c == 0 || c == 2 || c == 3) ? modelMap[w[2:0]] : '0;
        d   = refWrites(c) ? freeQ[0] : '0;
        p   = refWrites(c) ? modelMap[w[8:6]] : '0;
        ptr = PtrWidth'((alHead + alLog()) % Depth);
        return {a, b, d, p, ptr, c == 1, c == 2, c == 3};
    endfunction

    function automatic int alLog();
        return alEntry.size();
    endfunction

    task automatic applyRename(input logic [11:0] w);
        int c;
        logic [PhysWidth-1:0] d, p;
        c = refClass(w);
        d = '0;
        p = '0;
        if (refWrites(c)) begin
            p = modelMap[w[8:6]];
            d = freeQ.pop_front();
            modelMap[w[8:6]] = d;
        end
        alEntry.push_back({refWrites(c) ? w[8:6] : 3'd0, d, w[11:9] > 3'd5});
        alPrev.push_back(p);
        alWr.push_back(refWrites(c));
        renamedCount++;
    endtask

    task automatic popCommit();
        logic [PhysWidth-1:0] p;
        p = alPrev.pop_front();
        if (alWr.pop_front()) begin
            freeQ.push_back(p);
        end
        expCommit.push_back(alEntry.pop_front());
        alHead = (alHead + 1) % Depth;
    endtask

    // Compare outputs with the model while inputs are stable
    always @(negedge clk) begin : monitor
        bit alEmpty, expUpdate, accept;
        int c;
        if (!rst) begin
            if (commitValid) begin
                if (expCommit.size() == 0) begin
                    reportFailure("commitValid came without a committed entry");
                end else begin
                    checkCommit(commitLogDst, commitPhyDst, commitUndefined,
                        expCommit.pop_front());
                end
            end else if (expCommit.size() != 0) begin
                reportFailure("commitValid missing after a commit");
                void'(expCommit.pop_front());
            end
            alEmpty = alLog() == 0;
            if (waitOwn && alEmpty && storeQueueEmpty) begin
                waitOwn = 0;
            end
            expUpdate = 0;
            c = refClass(modelHeldWord);
            if (modelHeldValid) begin
                expUpdate = !flush && !(refWrites(c) && freeQ.size() == 0)
                    && alLog() < Depth && !waitOwn
                    && !((c == 4 || c == 5) && (!alEmpty || (c == 5 && !storeQueueEmpty)));
            end
            if (outValid !== expUpdate) begin
                reportMismatch($sformatf("outValid %b, expected %b", outValid, expUpdate));
            end
            if (inReady !== (!modelHeldValid || expUpdate)) begin
                reportMismatch($sformatf("inReady %b, expected %b", inReady,
                    !modelHeldValid || expUpdate));
            end
            accept = opValid && (!modelHeldValid || expUpdate);
            if (expUpdate) begin
                checkRename(outPhySrcA, outPhySrcB, outPhyDst, outPhyPrevDst, outActiveListPtr,
                    {outIsLoad, outIsStore, outIsBranch}, expectRename(modelHeldWord));
                applyRename(modelHeldWord);
                waitOwn = c == 4 || c == 5;
            end
            if (commit && !alEmpty) begin
                popCommit();
            end
            if (flush) begin
                waitOwn = 0;
            end
            if (expUpdate || flush) begin
                modelHeldValid = 0;
            end
            if (accept) begin
                modelHeldValid = 1;
                modelHeldWord  = opWord;
            end
        end
    end

    task automatic offerOp(input logic [11:0] word, input int maxCycles, output bit accepted);
        int n;
        opValid  = 1'b1;
        opWord   = word;
        accepted = 0;
        n = 0;
        while (!accepted && n < maxCycles) begin
            @(negedge clk);
            accepted = inReady;
            @(posedge clk);
            #1;
            n++;
        end
        opValid = 1'b0;
    endtask

    task automatic sendOp(input logic [11:0] word);
        bit accepted;
        offerOp(word, TotalOps * 40, accepted);
        if (!accepted) begin
            reportFailure("op was never accepted by the rename unit");
        end
    endtask

    task automatic waitCycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // Commit everything that is in flight
    task automatic drainAll();
        bit done;
        opValid = 1'b0;
        commit = 1'b1;
        storeQueueEmpty = 1'b1;
        flush = 1'b0;
        do begin
            @(posedge clk);
            #1;
            done = !modelHeldValid && alLog() == 0 && expCommit.size() == 0;
        end while (!done);
        commit = 1'b0;
        waitCycles(2);
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        if (errors == errorsBefore) begin
            $display("test %s: ok", name);
            passCount++;
        end else begin
            $display("test %s: FAILED with %0d errors", name, errors - errorsBefore);
            failCount++;
        end
    endtask

    // Fill the free list or the active list with no commits
    task automatic checkExhaustion(input int cls, input string name);
        int start, accepted;
        bit ok;
        start = renamedCount;
        accepted = 0;
        commit = 1'b0;
        for (int i = 0; i < 10; i++) begin
            offerOp(makeWord(cls, i % 8, 1, 2), 20, ok);
            if (ok) accepted++;
        end
        waitCycles(5);
        if (accepted != 9 || renamedCount - start != 8 || inReady !== 1'b0) begin
            reportFailure($sformatf("%s did not stall after 8 ops (%0d taken, %0d renamed)",
                name, accepted, renamedCount - start));
        end
        drainAll();
    endtask

    task automatic randomMix(input int count);
        int sent;
        bit taken;
        sent = 0;
        taken = 1;
        while (sent < count) begin
            if (taken) begin
                opWord = makeWord(randomBits(3), randomBits(3), randomBits(3), randomBits(3));
                opValid = 1'b1;
            end
            commit = randomBits(1);
            storeQueueEmpty = randomBits(2) != 0;
            flush = randomBits(5) == 0;
            @(negedge clk);
            taken = inReady;
            if (taken) sent++;
            @(posedge clk);
            #1;
        end
        drainAll();
    endtask

    initial begin : watchdog
        #(Period * (TotalOps * 40 + 2000));
        $display("Timeout: the tests did not finish in the allowed time");
        $display("sim failed");
        $finish;
    end

    initial begin : stimulus
        int base;
        rst = 1'b1;
        opValid = 1'b0;
        opWord = '0;
        commit = 1'b0;
        storeQueueEmpty = 1'b1;
        flush = 1'b0;
        for (int i = 0; i < 8; i++) modelMap[i] = PhysWidth'(i);
        for (int i = 8; i < PhysRegs; i++) freeQ.push_back(PhysWidth'(i));
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        base = errors;
        @(negedge clk);
        if (inReady !== 1'b1 || outValid !== 1'b0 || commitValid !== 1'b0) begin
            reportMismatch("outputs after reset are not idle");
        end
        @(posedge clk);
        #1;
        for (int i = 0; i < 3; i++) sendOp(makeWord(0, i + 1, i + 4, 7 - i));
        drainAll();
        finishTest("reset and first allocation", base);

        base = errors;
        for (int i = 0; i < 6; i++) sendOp(makeWord(i % 2, 1, 1, 2));
        drainAll();
        finishTest("dependency chain", base);

        base = errors;
        checkExhaustion(0, "free list");
        checkExhaustion(2, "active list");
        finishTest("exhaustion", base);

        base = errors;
        commit = 1'b1;
        for (int i = 0; i < 10; i++) sendOp(makeWord((i % 3 == 2) ? 7 : 0, i % 8, 3, 4));
        drainAll();
        finishTest("commit order and recycling", base);

        base = errors;
        sendOp(makeWord(0, 2, 1, 1));
        sendOp(makeWord(0, 3, 2, 2));
        sendOp(makeWord(4, 5, 0, 0));
        waitCycles(6);
        commit = 1'b1;
        sendOp(makeWord(0, 4, 5, 5));
        commit = 1'b0;
        waitCycles(6);
        commit = 1'b1;
        sendOp(makeWord(5, 0, 0, 0));
        storeQueueEmpty = 1'b0;
        waitCycles(6);
        storeQueueEmpty = 1'b1;
        sendOp(makeWord(1, 6, 5, 0));
        drainAll();
        finishTest("serialization", base);

        base = errors;
        randomMix(400);
        finishTest("random mix", base);

        $display("Summary: %0d tests passed, %0d failed, %0d ops renamed",
            passCount, failCount, renamedCount);
        if (errors == 0 && failCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+tests
src/RenameTypes.sv
src/RenameOpDecoder.sv
src/RenameSerializer.sv
src/RenameMapTable.sv
src/RenameActiveList.sv
src/RenameStage.sv
src/RenameUnit.sv
tests/RenameUnitTb.sv
